// ==== dcache.f ====
+incdir+hdl
hdl/cache_types_pkg.sv
hdl/mem_bus_pkg.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/refill_buffer.sv
hdl/dcache_ctrl.sv
hdl/dcache.sv
testbench/tb_clock.sv
testbench/tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dcache testbench with Verilator.
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache -Mdir "$BUILD" -f dcache.f
if [ $? -ne 0 ]; then
    echo "run_sim: compile failed"
    exit 1
fi

"./$BUILD/Vtb_dcache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -qxF '>>> PASS' "$LOG"; then
    exit 0
fi
echo "run_sim: pass line not found in $LOG"
exit 1

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int N_ENTRIES   = 16;
    localparam int MAX_WAIT    = 40;                          // cycles per request
    localparam int WATCHDOG_NS = N_ENTRIES * 40 * CLK_PERIOD;

    typedef struct packed {
        cpu_op_e   op;
        mem_addr_t addr;
        beat_t     wdata;
        strb_t     wstrb;
        beat_t     exp_rdata;
        logic      exp_miss;
        logic      exp_wb;
        mem_addr_t exp_wb_addr;
    } entry_t;

    logic      clk, rst, req_i, ready_o, valid_o;
    cpu_op_e   op_i;
    mem_addr_t addr_i, wr_addr_o, rd_addr_o;
    beat_t     wdata_i, rdata_o, rdata_i;
    strb_t     wstrb_i;
    logic      wr_req_o, wr_ready_i, rd_req_o, rd_ready_i, rvalid_i, rlast_i;
    line_t     wr_line_o;

    entry_t      stim_q[$];
    line_t       mem_img [logic [27:0]];    // memory contents after write-backs
    line_t       ref_img [logic [27:0]];    // what the processor should see
    mem_addr_t   wb_log[$];
    int unsigned rd_count = 0;
    int unsigned fail_count = 0;
    mem_addr_t   cur_addr, exp_wb_addr;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_tb_clock (.clk_o(clk));

    dcache i_dcache (
        .clk(clk), .rst(rst),
        .req_i(req_i), .op_i(op_i), .addr_i(addr_i), .wdata_i(wdata_i), .wstrb_i(wstrb_i),
        .ready_o(ready_o), .valid_o(valid_o), .rdata_o(rdata_o),
        .wr_req_o(wr_req_o), .wr_addr_o(wr_addr_o), .wr_line_o(wr_line_o),
        .wr_ready_i(wr_ready_i), .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .rd_ready_i(rd_ready_i), .rdata_i(rdata_i), .rvalid_i(rvalid_i), .rlast_i(rlast_i)
    );

    task automatic stop_on_failure();
        fail_count++;
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_beat(string name, beat_t got, beat_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(string name, mem_addr_t got, mem_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // each beat starts as {~addr, addr} of its own 8-byte address
    function automatic line_t init_line(mem_addr_t a);
        mem_addr_t lo;
        mem_addr_t hi;
        lo = {a[31:4], 4'h0};
        hi = lo + 32'd8;
        return {~hi, hi, ~lo, lo};
    endfunction

    function automatic line_t mem_line(mem_addr_t a);
        if (mem_img.exists(a[31:4])) return mem_img[a[31:4]];
        else return init_line(a);
    endfunction

    function automatic line_t ref_line(mem_addr_t a);
        if (ref_img.exists(a[31:4])) return ref_img[a[31:4]];
        else return init_line(a);
    endfunction

    // strobed bytes land at offset + byte, bytes past the line end drop out
    function automatic void apply_write(mem_addr_t a, beat_t data, strb_t strb);
        line_t line;
        int    pos;
        line = ref_line(a);
        for (int b = 0; b < 8; b++) begin
            pos = int'(a[3:0]) + b;
            if (strb[b] && pos < 16) line[pos*8 +: 8] = data[b*8 +: 8];
        end
        ref_img[a[31:4]] = line;
    endfunction

    function automatic void add_entry(cpu_op_e op, mem_addr_t addr, beat_t wdata, strb_t wstrb,
                                      beat_t exp_rdata, logic miss, logic wb, mem_addr_t wb_addr);
        stim_q.push_back(entry_t'{op, addr, wdata, wstrb, exp_rdata, miss, wb, wb_addr});
    endfunction

    function automatic void build_table();
        // set 5 gets tags 0, 1 and 2 in turn
        add_entry(OP_READ,  32'h0000_0050, 64'h0, 8'h00, 64'hffff_ffaf_0000_0050, 1, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_005c, 64'h0, 8'h00, 64'h0000_0000_ffff_ffa7, 0, 0, 32'h0);
        add_entry(OP_WRITE, 32'h0000_0052, 64'ha1b2, 8'h03, 64'h0, 0, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_0050, 64'h0, 8'h00, 64'hffff_ffaf_a1b2_0050, 0, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_0851, 64'h0, 8'h00, 64'h00ff_fff7_af00_0008, 1, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_1050, 64'h0, 8'h00, 64'hffff_efaf_0000_1050, 1, 1, 32'h50);
        add_entry(OP_READ,  32'h0000_0050, 64'h0, 8'h00, 64'hffff_ffaf_a1b2_0050, 1, 0, 32'h0);
        // write miss in set 6
        add_entry(OP_WRITE, 32'h0000_0868, 64'h1122_3344_0000_0000, 8'hf0, 64'h0, 1, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_086c, 64'h0, 8'h00, 64'h0000_0000_1122_3344, 0, 0, 32'h0);
        add_entry(OP_WRITE, 32'h0000_005b, 64'hcd, 8'h01, 64'h0, 0, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_0058, 64'h0, 8'h00, 64'hffff_ffa7_cd00_0058, 0, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_1050, 64'h0, 8'h00, 64'hffff_efaf_0000_1050, 0, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_0850, 64'h0, 8'h00, 64'hffff_f7af_0000_0850, 1, 1, 32'h50);
        add_entry(OP_READ,  32'h0000_005a, 64'h0, 8'h00, 64'h0000_ffff_ffa7_cd00, 1, 0, 32'h0);
        add_entry(OP_READ,  32'h0000_1050, 64'h0, 8'h00, 64'hffff_efaf_0000_1050, 1, 0, 32'h0);
        add_entry(OP_READ,  32'h8000_3ff7, 64'h0, 8'h00, 64'h0000_0000_0000_007f, 1, 0, 32'h0);
    endfunction

    task automatic serve_write_back();
        int unsigned delay;
        mem_addr_t   addr;
        line_t       line;
        delay = $urandom_range(3, 0);
        addr  = wr_addr_o;
        line  = wr_line_o;
        check_addr("wr_addr_o", addr, exp_wb_addr);
        check_line("wr_line_o", line, ref_line(addr));
        repeat (delay) begin
            @(negedge clk);
            check_flag("wr_req_o", wr_req_o, 1'b1);         // still held
            check_addr("wr_addr_o", wr_addr_o, addr);
            check_line("wr_line_o", wr_line_o, line);
        end
        wr_ready_i = 1'b1;
        @(negedge clk);
        wr_ready_i = 1'b0;
        mem_img[addr[31:4]] = line;
        wb_log.push_back(addr);
        $display("write-back %0d to %h", wb_log.size(), addr);
    endtask

    task automatic serve_line_read();
        int unsigned delay;
        mem_addr_t   addr;
        line_t       line;
        delay = $urandom_range(3, 0);
        addr  = rd_addr_o;
        check_addr("rd_addr_o", addr, {cur_addr[31:4], 4'h0});
        repeat (delay) begin
            @(negedge clk);
            check_flag("rd_req_o", rd_req_o, 1'b1);
            check_addr("rd_addr_o", rd_addr_o, addr);
        end
        rd_ready_i = 1'b1;
        @(negedge clk);
        rd_ready_i = 1'b0;
        rd_count++;
        line     = mem_line(addr);
        rvalid_i = 1'b1;                                    // low beat first
        rdata_i  = line[63:0];
        @(negedge clk);
        rvalid_i = 1'b0;
        repeat ($urandom_range(1, 0)) @(negedge clk);        // optional gap between beats
        rvalid_i = 1'b1;
        rlast_i  = 1'b1;
        rdata_i  = line[127:64];
        @(negedge clk);
        rvalid_i = 1'b0;
        rlast_i  = 1'b0;
        rdata_i  = '0;
    endtask

    task automatic run_entry(entry_t e, int idx);
        int unsigned rd_before;
        int unsigned wb_before;
        int          waited;
        @(negedge clk);
        check_flag("valid_o", valid_o, 1'b0);
        cur_addr    = e.addr;
        exp_wb_addr = e.exp_wb_addr;
        rd_before   = rd_count;
        wb_before   = wb_log.size();
        req_i   = 1'b1;
        op_i    = e.op;
        addr_i  = e.addr;
        wdata_i = e.wdata;
        wstrb_i = e.wstrb;
        waited  = 0;
        while (!ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > MAX_WAIT) begin
                $display("entry %0d was never accepted", idx);
                stop_on_failure();
            end
        end
        @(negedge clk);                                     // accepted at the edge just passed
        req_i  = 1'b0;
        waited = 1;
        while (!valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > MAX_WAIT) begin
                $display("entry %0d never completed, valid_o stayed low", idx);
                stop_on_failure();
            end
        end
        if (!e.exp_miss && waited != 1) begin
            $display("hit on entry %0d completed after %0d cycles instead of 1", idx, waited);
            stop_on_failure();
        end
        if (e.op == OP_READ) check_beat("rdata_o", rdata_o, e.exp_rdata);
        // hit write keeps the port busy, a miss keeps ready low through refill
        check_flag("ready_o", ready_o, !e.exp_miss && e.op == OP_READ);
        check_flag("rd_req_o", rd_count != rd_before, e.exp_miss);
        check_flag("wr_req_o", wb_log.size() != wb_before, e.exp_wb);
        if (e.op == OP_WRITE) apply_write(e.addr, e.wdata, e.wstrb);
    endtask

    // memory model
    initial begin
        void'($urandom(32'h7f37_5720));
        forever begin
            @(negedge clk);
            if (!rst && wr_req_o) begin
                serve_write_back();
            end else if (!rst && rd_req_o) begin
                serve_line_read();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all entries completed");
        stop_on_failure();
    end

    initial begin
        rst        = 1'b1;
        req_i      = 1'b0;
        op_i       = OP_READ;
        addr_i     = '0;
        wdata_i    = '0;
        wstrb_i    = '0;
        wr_ready_i = 1'b0;
        rd_ready_i = 1'b0;
        rdata_i    = '0;
        rvalid_i   = 1'b0;
        rlast_i    = 1'b0;
        build_table();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_flag("ready_o", ready_o, 1'b1);
        check_flag("valid_o", valid_o, 1'b0);
        check_flag("wr_req_o", wr_req_o, 1'b0);
        check_flag("rd_req_o", rd_req_o, 1'b0);
        for (int i = 0; i < stim_q.size(); i++) begin
            run_entry(stim_q[i], i);
        end
        if (fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;    // first rising edge at half a period
        end
    end

endmodule

// ==== hdl/dcache.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache (
    input  logic                       clk,
    input  logic                       rst,
    // processor side
    input  logic                       req_i,
    input  cache_types_pkg::cpu_op_e   op_i,
    input  mem_bus_pkg::mem_addr_t     addr_i,
    input  mem_bus_pkg::beat_t         wdata_i,
    input  cache_types_pkg::strb_t     wstrb_i,
    output logic                       ready_o,
    output logic                       valid_o,
    output mem_bus_pkg::beat_t         rdata_o,
    // bus side
    output logic                       wr_req_o,
    output mem_bus_pkg::mem_addr_t     wr_addr_o,
    output mem_bus_pkg::line_t         wr_line_o,
    input  logic                       wr_ready_i,
    output logic                       rd_req_o,
    output mem_bus_pkg::mem_addr_t     rd_addr_o,
    input  logic                       rd_ready_i,
    input  mem_bus_pkg::beat_t         rdata_i,
    input  logic                       rvalid_i,
    input  logic                       rlast_i
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    index_t     lookup_index;
    tag_t       lookup_tag;
    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    logic       lru_wen;
    logic       tag_wen;
    way_t       tag_way;
    index_t     tag_index;
    tag_t       tag_wdata;
    logic       dirty;
    logic       ds_rd_en;
    index_t     ds_index;
    logic       ds_wen;
    way_t       ds_way;
    line_mask_t ds_wmask;
    line_t      ds_wline;
    line_t      way0_line;
    line_t      way1_line;
    line_t      refill_line;
    logic       refill_clear;

    // lookup straight from the incoming address
    assign lookup_index = addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign lookup_tag   = addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];

    tag_store i_tag_store (
        .clk            (clk),
        .rst            (rst),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .lru_wen_i      (lru_wen),
        .tag_wen_i      (tag_wen),
        .tag_way_i      (tag_way),
        .tag_index_i    (tag_index),
        .tag_i          (tag_wdata),
        .dirty_i        (dirty),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    data_store i_data_store (
        .clk         (clk),
        .rd_en_i     (ds_rd_en),
        .index_i     (ds_index),
        .wen_i       (ds_wen),
        .way_i       (ds_way),
        .wmask_i     (ds_wmask),
        .wline_i     (ds_wline),
        .way0_line_o (way0_line),
        .way1_line_o (way1_line)
    );

    refill_buffer i_refill_buffer (
        .clk      (clk),
        .rst      (rst),
        .clear_i  (refill_clear),
        .rvalid_i (rvalid_i),
        .rlast_i  (rlast_i),
        .rdata_i  (rdata_i),
        .line_o   (refill_line)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .op_i           (op_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .wstrb_i        (wstrb_i),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .rdata_o        (rdata_o),
        .wr_req_o       (wr_req_o),
        .wr_addr_o      (wr_addr_o),
        .wr_line_o      (wr_line_o),
        .wr_ready_i     (wr_ready_i),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .rd_ready_i     (rd_ready_i),
        .rvalid_i       (rvalid_i),
        .rlast_i        (rlast_i),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .lru_wen_o      (lru_wen),
        .tag_wen_o      (tag_wen),
        .tag_way_o      (tag_way),
        .tag_index_o    (tag_index),
        .tag_o          (tag_wdata),
        .dirty_o        (dirty),
        .way0_line_i    (way0_line),
        .way1_line_i    (way1_line),
        .refill_line_i  (refill_line),
        .ds_rd_en_o     (ds_rd_en),
        .ds_index_o     (ds_index),
        .ds_wen_o       (ds_wen),
        .ds_way_o       (ds_way),
        .ds_wmask_o     (ds_wmask),
        .ds_wline_o     (ds_wline),
        .refill_clear_o (refill_clear)
    );

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // processor side
    input  logic                       req_i,
    input  cache_types_pkg::cpu_op_e   op_i,
    input  mem_bus_pkg::mem_addr_t     addr_i,
    input  mem_bus_pkg::beat_t         wdata_i,
    input  cache_types_pkg::strb_t     wstrb_i,
    output logic                       ready_o,
    output logic                       valid_o,
    output mem_bus_pkg::beat_t         rdata_o,
    // bus side
    output logic                       wr_req_o,
    output mem_bus_pkg::mem_addr_t     wr_addr_o,
    output mem_bus_pkg::line_t         wr_line_o,
    input  logic                       wr_ready_i,
    output logic                       rd_req_o,
    output mem_bus_pkg::mem_addr_t     rd_addr_o,
    input  logic                       rd_ready_i,
    input  logic                       rvalid_i,
    input  logic                       rlast_i,
    // tag store
    input  logic                       hit_i,
    input  cache_types_pkg::way_t      hit_way_i,
    input  cache_types_pkg::way_t      victim_way_i,
    input  logic                       victim_dirty_i,
    input  cache_types_pkg::tag_t      victim_tag_i,
    output logic                       lru_wen_o,
    output logic                       tag_wen_o,
    output cache_types_pkg::way_t      tag_way_o,
    output cache_types_pkg::index_t    tag_index_o,
    output cache_types_pkg::tag_t      tag_o,
    output logic                       dirty_o,
    // data store and refill buffer
    input  mem_bus_pkg::line_t         way0_line_i,
    input  mem_bus_pkg::line_t         way1_line_i,
    input  mem_bus_pkg::line_t         refill_line_i,
    output logic                       ds_rd_en_o,
    output cache_types_pkg::index_t    ds_index_o,
    output logic                       ds_wen_o,
    output cache_types_pkg::way_t      ds_way_o,
    output mem_bus_pkg::line_mask_t    ds_wmask_o,
    output mem_bus_pkg::line_t         ds_wline_o,
    output logic                       refill_clear_o
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    dc_state_e state_q, state_d;

    // request buffer
    cpu_op_e   op_r;
    mem_addr_t addr_r;
    beat_t     wdata_r;
    strb_t     wstrb_r;
    way_t      hit_way_r;
    way_t      victim_way_r;
    logic      victim_dirty_r;
    tag_t      victim_tag_r;

    logic                  accept;
    logic                  hit_write;
    logic                  refill;
    tag_t                  tag_r;
    index_t                index_r;
    offset_t               offset_r;
    logic [`DC_BEAT_W-1:0] beat_mask;
    line_mask_t            merge_mask;
    line_t                 wdata_line;
    line_t                 src_line;
    beat_t                 half_beat;

    assign accept = req_i && ready_o;

    assign tag_r    = addr_r[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index_r  = addr_r[`DC_OFFSET_W +: `DC_INDEX_W];
    assign offset_r = addr_r[`DC_OFFSET_W-1:0];

    always_ff @(posedge clk) begin
        if (accept) begin
            op_r           <= op_i;
            addr_r         <= addr_i;
            wdata_r        <= wdata_i;
            wstrb_r        <= wstrb_i;
            hit_way_r      <= hit_way_i;
            victim_way_r   <= victim_way_i;
            victim_dirty_r <= victim_dirty_i;
            victim_tag_r   <= victim_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_LOOKUP: begin
                if (accept) begin
                    state_d = hit_i ? S_LOOKUP : S_MISS;
                end else begin
                    state_d = S_IDLE;
                end
            end
            S_MISS: begin
                if (!victim_dirty_r || wr_ready_i) state_d = S_REPLACE;
            end
            S_REPLACE: begin
                if (rd_ready_i) state_d = S_RDATA;
            end
            S_RDATA: begin
                if (rvalid_i && rlast_i) state_d = S_REFILL;
            end
            default: state_d = S_IDLE;          // refill done
        endcase
    end

    assign hit_write = (state_q == S_LOOKUP) && (op_r == OP_WRITE);
    assign refill    = (state_q == S_REFILL);

    // no lookup while the hit write holds the port
    assign ready_o = (state_q == S_IDLE) || ((state_q == S_LOOKUP) && (op_r == OP_READ));
    assign valid_o = (state_q == S_LOOKUP) || refill;

    // bus requests
    assign wr_req_o       = (state_q == S_MISS) && victim_dirty_r;
    assign wr_addr_o      = {victim_tag_r, index_r, {`DC_OFFSET_W{1'b0}}};
    assign wr_line_o      = victim_way_r ? way1_line_i : way0_line_i;
    assign rd_req_o       = (state_q == S_REPLACE);
    assign rd_addr_o      = {addr_r[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign refill_clear_o = rd_req_o && rd_ready_i;

    // byte strobes widened to a bit mask and moved into line position
    always_comb begin
        for (int b = 0; b < `DC_STRB_W; b++) begin
            beat_mask[b*8 +: 8] = {8{wstrb_r[b]}};
        end
    end

    assign wdata_line = line_t'(wdata_r) << {offset_r, 3'b000};
    assign merge_mask = (op_r == OP_WRITE) ?
                        (line_mask_t'(beat_mask) << {offset_r, 3'b000}) : '0;

    // tag and data writes share way and timing
    assign lru_wen_o   = accept;
    assign tag_wen_o   = hit_write || refill;
    assign tag_way_o   = refill ? victim_way_r : hit_way_r;
    assign tag_index_o = index_r;
    assign tag_o       = tag_r;
    assign dirty_o     = (op_r == OP_WRITE);

    assign ds_rd_en_o = accept;
    assign ds_wen_o   = tag_wen_o;
    assign ds_way_o   = tag_way_o;
    assign ds_index_o = ds_wen_o ? index_r : addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign ds_wmask_o = refill ? '1 : merge_mask;           // full line on refill
    assign ds_wline_o = refill ? ((refill_line_i & ~merge_mask) | (wdata_line & merge_mask))
                               : wdata_line;

    // read alignment
    assign src_line  = refill ? refill_line_i : (hit_way_r ? way1_line_i : way0_line_i);
    assign half_beat = offset_r[`DC_OFFSET_W-1] ? src_line[`DC_LINE_W-1 -: `DC_BEAT_W]
                                                 : src_line[`DC_BEAT_W-1:0];
    assign rdata_o   = half_beat >> {offset_r[2:0], 3'b000};

    a_one_bus_req: assert property (
        @(posedge clk) disable iff (rst) !(wr_req_o && rd_req_o)
    );

    a_no_valid_idle: assert property (
        @(posedge clk) disable iff (rst) state_q == S_IDLE |-> !valid_o
    );

endmodule

// ==== hdl/refill_buffer.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module refill_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                clear_i,
    input  logic                rvalid_i,
    input  logic                rlast_i,
    input  mem_bus_pkg::beat_t  rdata_i,
    output mem_bus_pkg::line_t  line_o
);
    localparam int CNT_W = $clog2(`DC_BEATS);

    logic [CNT_W-1:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            beat_cnt <= '0;
        end else if (rvalid_i) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // low beat first
    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            line_o[beat_cnt*`DC_BEAT_W +: `DC_BEAT_W] <= rdata_i;
        end
    end

    a_last_beat: assert property (
        @(posedge clk) disable iff (rst)
        rvalid_i && rlast_i |-> beat_cnt == CNT_W'(`DC_BEATS - 1)
    );

endmodule

// ==== hdl/data_store.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module data_store (
    input  logic                       clk,
    input  logic                       rd_en_i,
    input  cache_types_pkg::index_t    index_i,
    input  logic                       wen_i,
    input  cache_types_pkg::way_t      way_i,
    input  mem_bus_pkg::line_mask_t   wmask_i,
    input  mem_bus_pkg::line_t        wline_i,
    output mem_bus_pkg::line_t        way0_line_o,
    output mem_bus_pkg::line_t        way1_line_o
);
    import mem_bus_pkg::*;

    line_t mem_q [`DC_WAYS][`DC_SETS];

    // one address for both read and write
    always_ff @(posedge clk) begin
        if (wen_i) begin
            mem_q[way_i][index_i] <= (mem_q[way_i][index_i] & ~wmask_i) |
                                     (wline_i & wmask_i);
        end
        if (rd_en_i) begin
            way0_line_o <= mem_q[0][index_i];   // held until next read
            way1_line_o <= mem_q[1][index_i];
        end
    end

    // controller must never share the port in one cycle
    a_single_port: assert property (
        @(posedge clk) !(rd_en_i && wen_i)
    );

endmodule

// ==== hdl/tag_store.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module tag_store (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_types_pkg::index_t lookup_index_i,
    input  cache_types_pkg::tag_t   lookup_tag_i,
    input  logic                    lru_wen_i,
    input  logic                    tag_wen_i,
    input  cache_types_pkg::way_t   tag_way_i,
    input  cache_types_pkg::index_t tag_index_i,
    input  cache_types_pkg::tag_t   tag_i,
    input  logic                    dirty_i,
    output logic                    hit_o,
    output cache_types_pkg::way_t   hit_way_o,
    output cache_types_pkg::way_t   victim_way_o,
    output logic                    victim_dirty_o,
    output cache_types_pkg::tag_t   victim_tag_o
);
    import cache_types_pkg::*;

    tag_t               tag_q   [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
    logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
    logic [`DC_SETS-1:0] mru_q;            // recently used way per set
    logic [`DC_WAYS-1:0] way_hit;

    // tag compare in both ways
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[w][lookup_index_i] &&
                         (tag_q[w][lookup_index_i] == lookup_tag_i);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid way first, then the one not recently used
    always_comb begin
        if (!valid_q[0][lookup_index_i]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][lookup_index_i]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~mru_q[lookup_index_i];
        end
    end

    assign victim_dirty_o = valid_q[victim_way_o][lookup_index_i] &&
                            dirty_q[victim_way_o][lookup_index_i];
    assign victim_tag_o   = tag_q[victim_way_o][lookup_index_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            mru_q <= '0;
        end else begin
            if (tag_wen_i) begin
                valid_q[tag_way_i][tag_index_i] <= 1'b1;
            end
            if (lru_wen_i) begin
                mru_q[lookup_index_i] <= hit_o ? hit_way_o : victim_way_o;
            end
        end
    end

    // tag and dirty only matter while valid
    always_ff @(posedge clk) begin
        if (tag_wen_i) begin
            tag_q[tag_way_i][tag_index_i]   <= tag_i;
            dirty_q[tag_way_i][tag_index_i] <= dirty_i;
        end
    end

endmodule

// ==== hdl/mem_bus_pkg.sv ====
`include "dcache_consts.svh"

package mem_bus_pkg;

    typedef logic [`DC_ADDR_W-1:0] mem_addr_t;
    typedef logic [`DC_BEAT_W-1:0] beat_t;
    typedef logic [`DC_LINE_W-1:0] line_t;

    // one bit per data bit of a line
    typedef logic [`DC_LINE_W-1:0] line_mask_t;

endpackage

// ==== hdl/cache_types_pkg.sv ====
`include "dcache_consts.svh"

package cache_types_pkg;

    // processor operation, encoding matches the op input
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_e;

    // controller states
    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,    // hit, completes here
        S_MISS,      // write-back of a dirty victim
        S_REPLACE,   // line read request
        S_RDATA,     // collecting beats
        S_REFILL     // line written into the arrays
    } dc_state_e;

    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    typedef logic                    way_t;
    typedef logic [`DC_STRB_W-1:0]   strb_t;

endpackage

// ==== hdl/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_WAYS      2
`define DC_SETS      128
`define DC_INDEX_W   7
`define DC_OFFSET_W  4     // byte offset in a 16-byte line
`define DC_TAG_W     21

// data path widths
`define DC_ADDR_W    32
`define DC_BEAT_W    64
`define DC_LINE_W    128
`define DC_STRB_W    8
`define DC_BEATS     2     // bus beats per line

`endif
